// File: vlog.f
src/motion_pkg.sv
src/spi_word_port.sv
src/command_fsm.sv
src/move_fifo.sv
src/step_generator.sv
src/motion_core.sv
verif/motion_core_checker.sv
verif/tb_motion_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_motion_core \
  -f vlog.f -o tb_motion_core > build.log 2>&1 \
  && ./obj_dir/tb_motion_core +verilator+error+limit+1000 > sim.log 2>&1

cat sim.log 2>/dev/null
grep -q "^TB PASSED$" sim.log 2>/dev/null && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: verif/tb_motion_core.sv
// Motion controller testbench
`timescale 1ns/1ps

module tb_motion_core;
  import motion_pkg::*;

  localparam int buffer_depth = 4;
  localparam int tick_divisor = 4;
  localparam int sck_half     = 4;   // Clock cycles per SCK half-period
  localparam int xfer_gap     = 12;  // Lets the FSM finish before the next transfer
  localparam int xfer_cycles  = 2 * sck_half + 2 * sck_half * word_bits + xfer_gap + 1;
  localparam int num_xfers    = 23;
  localparam int long_dur     = 1536;
  localparam int move_cycles  = 10 * (64 * tick_divisor + 16) +
                                6 * (long_dur * tick_divisor + 16);
  localparam int cycle_limit  = 300 + num_xfers * xfer_cycles + move_cycles + 2000;

  logic                  buffered_clk = 1'b0;
  logic                  resetn_in;
  logic                  sck;
  logic                  cs_n;
  logic                  copi;
  logic                  cipo;
  logic [num_motors-1:0] step;
  logic [num_motors-1:0] dir;
  logic [num_motors-1:0] enable_out;
  logic                  buffer_dtr;
  logic                  move_done;

  logic [31:0]           lfsr_state = 32'h7867_1b81;
  logic [63:0]           exp_q [$];
  logic [63:0]           got_q [$];
  string                 tag_q [$];
  int                    error_count = 0;
  int                    check_count = 0;
  int                    cycle_count = 0;

  // Expected steps and dir per accepted move, in execution order
  int                    ref_steps [32][num_motors];
  logic [num_motors-1:0] ref_dir [32];
  int                    num_ref = 0;
  int                    exp_total [num_motors] = '{default: 0};
  int                    step_total [num_motors] = '{default: 0};
  int                    cur_idx [num_motors] = '{default: 0};
  int                    cur_cnt [num_motors] = '{default: 0};

  always #4 buffered_clk = ~buffered_clk;

  motion_core #(
    .buffer_depth (buffer_depth),
    .tick_divisor (tick_divisor)
  ) motion_core_inst (
    .buffered_clk (buffered_clk),
    .resetn_in    (resetn_in),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .cipo         (cipo),
    .step         (step),
    .dir          (dir),
    .enable_out   (enable_out),
    .buffer_dtr   (buffer_dtr),
    .move_done    (move_done)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);  // One step per bit
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  // Carries out of a 16-bit accumulator over dur ticks
  function automatic int expected_steps(input logic [15:0] inc, input logic [15:0] dur);
    logic [31:0] prod;
    prod = {16'd0, inc} * {16'd0, dur};
    expected_steps = int'({16'd0, prod[31:16]});
  endfunction

  function automatic status_t expected_status(input opcode_t last, input int done,
      input int free, input logic ovf, input logic busy, input logic [1:0] en);
    status_t s;
    s            = '0;
    s.last_op    = last;
    s.moves_done = 8'(done);
    s.free_slots = 4'(free);
    s.overflow   = ovf;
    s.busy       = busy;
    s.enable     = en;
    expected_status = s;
  endfunction

  function automatic logic [63:0] command_word(input opcode_t op, input logic [1:0] mask,
      input move_t m);
    logic [63:0] w;
    w        = '0;
    w[63:56] = op;
    w[49:48] = mask;
    w[47:32] = m.inc0;
    w[31:16] = m.inc1;
    w[15:0]  = m.duration;
    command_word = w;
  endfunction

  task automatic expect_value(input string tag, input logic [63:0] exp, input logic [63:0] got);
    tag_q.push_back(tag);
    exp_q.push_back(exp);
    got_q.push_back(got);
  endtask

  // Mode 0 transfer with MSB first and cipo read just before each rising SCK
  task automatic spi_transfer(input logic [63:0] tx, output logic [63:0] rx);
    @(posedge buffered_clk);
    cs_n <= 1'b0;
    copi <= tx[63];
    repeat (2 * sck_half) @(posedge buffered_clk);
    for (int i = word_bits - 1; i >= 0; i--) begin
      rx[i] = cipo;
      sck <= 1'b1;
      repeat (sck_half) @(posedge buffered_clk);
      sck <= 1'b0;
      if (i > 0) begin
        copi <= tx[i-1];
      end
      repeat (sck_half) @(posedge buffered_clk);
    end
    cs_n <= 1'b1;
    repeat (xfer_gap) @(posedge buffered_clk);
  endtask

  task automatic random_move(input int dur, output move_t m);
    logic [31:0] r;
    draw_bits(2, r);
    m.dir = r[1:0];
    draw_bits(16, r);
    m.inc0 = r[15:0];
    draw_bits(16, r);
    m.inc1 = r[15:0];
    m.duration = 16'(dur);
  endtask

  task automatic record_move(input move_t m);
    ref_steps[num_ref][0] = expected_steps(m.inc0, m.duration);
    ref_steps[num_ref][1] = expected_steps(m.inc1, m.duration);
    ref_dir[num_ref]      = m.dir;
    exp_total[0] += ref_steps[num_ref][0];
    exp_total[1] += ref_steps[num_ref][1];
    num_ref++;
  endtask

  task automatic wait_move_done();
    @(posedge buffered_clk);
    while (!move_done) @(posedge buffered_clk);
  endtask

  task automatic check_step_totals(input string phase);
    expect_value({phase, " axis 0 steps"}, 64'(exp_total[0]), 64'(step_total[0]));
    expect_value({phase, " axis 1 steps"}, 64'(exp_total[1]), 64'(step_total[1]));
  endtask

  // Compare process
  always @(posedge buffered_clk) begin
    string       tag;
    logic [63:0] e;
    logic [63:0] g;
    while (got_q.size() > 0) begin
      tag = tag_q.pop_front();
      e   = exp_q.pop_front();
      g   = got_q.pop_front();
      check_count++;
      assert (g === e) else begin
        error_count++;
        $display("ERROR @%0t: %s expected %h got %h", $time, tag, e, g);
      end
    end
  end

  // Counts steps and matches each one to its move for the dir check
  always @(posedge buffered_clk) begin
    for (int a = 0; a < num_motors; a++) begin
      if (step[a]) begin
        while (cur_idx[a] < num_ref && cur_cnt[a] >= ref_steps[cur_idx[a]][a]) begin
          cur_idx[a]++;
          cur_cnt[a] = 0;
        end
        assert (cur_idx[a] < num_ref && dir[a] == ref_dir[cur_idx[a]][a]) else begin
          error_count++;
          $display("ERROR @%0t: axis %0d step in move %0d has wrong dir %b",
                   $time, a, cur_idx[a], dir[a]);
        end
        cur_cnt[a]++;
        step_total[a]++;
      end
    end
  end

  always @(posedge buffered_clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: run did not complete within %0d clock cycles", cycle_limit);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    logic [63:0] rx;
    logic [31:0] r;
    logic [1:0]  mask;
    move_t       m;
    int          chk_fails;
    resetn_in = 1'b0;
    sck       = 1'b0;
    cs_n      = 1'b1;
    copi      = 1'b0;
    m         = '0;
    repeat (2) @(posedge buffered_clk);
    resetn_in <= 1'b1;
    repeat (260) @(posedge buffered_clk);  // Internal reset stretch
    wait_move_done();

    expect_value("buffer_dtr after reset", 64'd1, {63'd0, buffer_dtr});
    spi_transfer(command_word(op_nop, 2'b00, m), rx);
    expect_value("status after reset", expected_status(op_nop, 0, 4, 0, 0, 0), rx);
    expect_value("move_done after reset", 64'd1, {63'd0, move_done});

    draw_bits(2, r);
    mask = r[1:0];
    spi_transfer(command_word(op_enable, mask, m), rx);
    expect_value("status before enable", expected_status(op_nop, 0, 4, 0, 0, 0), rx);
    expect_value("enable_out", {62'd0, mask}, {62'd0, enable_out});
    spi_transfer(command_word(op_nop, 2'b00, m), rx);
    expect_value("status after enable", expected_status(op_enable, 0, 4, 0, 0, mask), rx);

    for (int k = 0; k < 10; k++) begin
      draw_bits(6, r);
      random_move(16 + int'(r[5:0]) % 49, m);
      while (!buffer_dtr) @(posedge buffered_clk);
      record_move(m);
      spi_transfer(command_word(op_move, m.dir, m), rx);
    end
    wait_move_done();
    check_step_totals("random moves");
    spi_transfer(command_word(op_nop, 2'b00, m), rx);
    expect_value("status after moves", expected_status(op_move, 10, 4, 0, 0, mask), rx);

    // First move goes straight to the generator, the buffer takes depth more
    for (int k = 0; k < 6; k++) begin
      random_move(long_dur, m);
      if (k < buffer_depth + 1) begin
        record_move(m);
      end
      spi_transfer(command_word(op_move, m.dir, m), rx);
    end
    spi_transfer(command_word(op_nop, 2'b00, m), rx);
    expect_value("status on overflow", expected_status(op_move, 10, 0, 1, 1, mask), rx);
    wait_move_done();
    check_step_totals("long moves");
    spi_transfer(command_word(op_clear, 2'b00, m), rx);
    expect_value("status before clear",
                 expected_status(op_nop, 11 + buffer_depth, 4, 1, 0, mask), rx);
    spi_transfer(command_word(op_nop, 2'b00, m), rx);
    expect_value("status after clear", expected_status(op_clear, 0, 4, 0, 0, mask), rx);

    while (got_q.size() > 0) @(posedge buffered_clk);
    @(posedge buffered_clk);
    chk_fails = motion_core_inst.checker_inst.fail_count;
    $display("Checks: %0d, compare errors: %0d, assertion failures: %0d",
             check_count, error_count, chk_fails);
    if (error_count == 0 && chk_fails == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// File: verif/motion_core_checker.sv
// Motion core protocol checks
`timescale 1ns/1ps

module motion_core_checker (
  input logic                              buffered_clk,
  input logic                              resetn,
  input logic                              move_req,
  input logic                              move_ack,
  input logic                              running,
  input logic [motion_pkg::num_motors-1:0] step,
  input logic [motion_pkg::num_motors-1:0] enable_out
);

  int fail_count = 0;

  // Ack is only a response to a pending request
  ack_needs_req: assert property (@(posedge buffered_clk) disable iff (!resetn)
    $rose(move_ack) |-> $past(move_req))
  else begin
    fail_count++;
    $error("move_ack rose without move_req");
  end

  req_held: assert property (@(posedge buffered_clk) disable iff (!resetn)
    move_req && !move_ack |=> move_req)
  else begin
    fail_count++;
    $error("move_req dropped before move_ack");
  end

  step_in_move: assert property (@(posedge buffered_clk) disable iff (!resetn)
    |step |-> running)
  else begin
    fail_count++;
    $error("Step pulse outside a running move");
  end

  enable_off_in_reset: assert property (@(posedge buffered_clk)
    !resetn |=> enable_out == '0)
  else begin
    fail_count++;
    $error("enable_out active during reset");
  end

endmodule

bind motion_core motion_core_checker checker_inst (
  .buffered_clk (buffered_clk),
  .resetn       (resetn),
  .move_req     (move_req),
  .move_ack     (move_ack),
  .running      (running),
  .step         (step),
  .enable_out   (enable_out)
);

// File: src/motion_core.sv
// Two-axis motion controller top
`timescale 1ns/1ps

module motion_core #(
  parameter int buffer_depth = 8,
  parameter int tick_divisor = 4
) (
  input  logic                              buffered_clk,
  input  logic                              resetn_in,
  input  logic                              sck,
  input  logic                              cs_n,
  input  logic                              copi,
  output logic                              cipo,
  output logic [motion_pkg::num_motors-1:0] step,
  output logic [motion_pkg::num_motors-1:0] dir,
  output logic [motion_pkg::num_motors-1:0] enable_out,
  output logic                              buffer_dtr,
  output logic                              move_done
);
  import motion_pkg::*;

  logic [7:0]           resetn_counter;
  logic                 resetn;
  logic [word_bits-1:0] rx_word;
  logic                 rx_valid;
  status_t              tx_word;
  logic                 push;
  move_t                push_move;
  logic                 full;
  logic                 empty;
  logic [free_bits-1:0] free_slots;
  logic                 move_req;
  logic                 move_ack;
  move_t                head_move;
  logic                 running;
  logic                 move_complete;

  // Internal reset releases once the counter saturates
  assign resetn = &resetn_counter;

  always_ff @(posedge buffered_clk) begin
    if (!resetn_in) begin
      resetn_counter <= '0;
    end else begin
      resetn_counter <= resetn_counter + {7'd0, ~resetn};
    end
  end

  assign buffer_dtr = ~full;
  assign move_done  = empty & ~running;  // Nothing queued and idle

  spi_word_port port_inst (
    .buffered_clk (buffered_clk),
    .resetn       (resetn),
    .sck          (sck),
    .cs_n         (cs_n),
    .copi         (copi),
    .tx_word      (tx_word),
    .cipo         (cipo),
    .rx_word      (rx_word),
    .rx_valid     (rx_valid)
  );

  command_fsm fsm_inst (
    .buffered_clk  (buffered_clk),
    .resetn        (resetn),
    .rx_word       (rx_word),
    .rx_valid      (rx_valid),
    .full          (full),
    .free_slots    (free_slots),
    .move_complete (move_complete),
    .running       (running),
    .tx_word       (tx_word),
    .push          (push),
    .push_move     (push_move),
    .enable_out    (enable_out)
  );

  move_fifo #(
    .buffer_depth (buffer_depth)
  ) fifo_inst (
    .buffered_clk (buffered_clk),
    .resetn       (resetn),
    .push         (push),
    .push_move    (push_move),
    .move_req     (move_req),
    .full         (full),
    .empty        (empty),
    .free_slots   (free_slots),
    .move_ack     (move_ack),
    .head_move    (head_move)
  );

  step_generator #(
    .tick_divisor (tick_divisor)
  ) gen_inst (
    .buffered_clk  (buffered_clk),
    .resetn        (resetn),
    .move_ack      (move_ack),
    .head_move     (head_move),
    .move_req      (move_req),
    .step          (step),
    .dir           (dir),
    .running       (running),
    .move_complete (move_complete)
  );

endmodule

// File: src/step_generator.sv
// DDA step pulse generator
`timescale 1ns/1ps

module step_generator #(
  parameter int tick_divisor = 4
) (
  input  logic                              buffered_clk,
  input  logic                              resetn,
  input  logic                              move_ack,
  input  motion_pkg::move_t                 head_move,
  output logic                              move_req,
  output logic [motion_pkg::num_motors-1:0] step,
  output logic [motion_pkg::num_motors-1:0] dir,
  output logic                              running,
  output logic                              move_complete
);
  import motion_pkg::*;

  localparam int tick_bits = $clog2(tick_divisor) + 1;

  typedef enum logic [1:0] {
    request,
    wait_release,
    run
  } state_t;

  state_t               state;
  logic [tick_bits-1:0] tick_cnt;
  logic                 tick;
  logic [dur_bits-1:0]  remaining;
  logic [acc_bits-1:0]  inc [num_motors];
  logic [acc_bits-1:0]  acc [num_motors];
  logic [acc_bits:0]    acc_sum [num_motors];

  assign move_req = state == request;
  assign running  = state != request;
  assign tick     = (state == run) && (tick_cnt == tick_bits'(tick_divisor - 1));

  // Last tick of a move, or a zero-length move right after the handshake
  assign move_complete = (tick && remaining == dur_bits'(1)) ||
                         (state == wait_release && !move_ack && remaining == '0);

  always_comb begin
    for (int i = 0; i < num_motors; i++) begin
      acc_sum[i] = {1'b0, acc[i]} + {1'b0, inc[i]};
      step[i]    = tick & acc_sum[i][acc_bits];  // Carry out gives a step
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (state == request && move_ack) begin
      inc[0] <= head_move.inc0;
      inc[1] <= head_move.inc1;
      for (int i = 0; i < num_motors; i++) begin
        acc[i] <= '0;
      end
    end else if (tick) begin
      for (int i = 0; i < num_motors; i++) begin
        acc[i] <= acc_sum[i][acc_bits-1:0];
      end
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      state     <= request;
      tick_cnt  <= '0;
      remaining <= '0;
      dir       <= '0;
    end else begin
      case (state)
        request: begin
          if (move_ack) begin
            dir       <= head_move.dir;  // Held through the move
            remaining <= head_move.duration;
            tick_cnt  <= '0;
            state     <= wait_release;
          end
        end
        wait_release: begin
          if (!move_ack) begin
            state <= (remaining == '0) ? request : run;
          end
        end
        run: begin
          if (tick) begin
            tick_cnt  <= '0;
            remaining <= remaining - 1'b1;
            if (remaining == dur_bits'(1)) begin
              state <= request;
            end
          end else begin
            tick_cnt <= tick_cnt + 1'b1;
          end
        end
        default: state <= request;
      endcase
    end
  end

endmodule

// File: src/move_fifo.sv
// Move buffer with handshake pop
`timescale 1ns/1ps

module move_fifo #(
  parameter int buffer_depth = 8
) (
  input  logic                             buffered_clk,
  input  logic                             resetn,
  input  logic                             push,
  input  motion_pkg::move_t                push_move,
  input  logic                             move_req,
  output logic                             full,
  output logic                             empty,
  output logic [motion_pkg::free_bits-1:0] free_slots,
  output logic                             move_ack,
  output motion_pkg::move_t                head_move
);
  import motion_pkg::*;

  localparam int ptr_bits = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;
  localparam int cnt_bits = $clog2(buffer_depth + 1);

  move_t               mem [buffer_depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push_ok;
  logic                pop;

  function automatic logic [ptr_bits-1:0] next_ptr(input logic [ptr_bits-1:0] ptr);
    next_ptr = (ptr == ptr_bits'(buffer_depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full       = count == cnt_bits'(buffer_depth);
  assign empty      = count == '0;
  assign free_slots = free_bits'(buffer_depth - count);
  assign head_move  = mem[rd_ptr];
  assign push_ok    = push & ~full;     // Dropped when full
  assign pop        = move_ack & ~move_req;  // Fourth phase

  always_ff @(posedge buffered_clk) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_move;
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      move_ack <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push_ok, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Ack only with a valid head, drop once req is released
      if (!move_ack && move_req && !empty) begin
        move_ack <= 1'b1;
      end else if (pop) begin
        move_ack <= 1'b0;
      end
    end
  end

endmodule

// File: src/command_fsm.sv
// Command decoder and status builder
`timescale 1ns/1ps

module command_fsm (
  input  logic                              buffered_clk,
  input  logic                              resetn,
  input  logic [motion_pkg::word_bits-1:0]  rx_word,
  input  logic                              rx_valid,
  input  logic                              full,
  input  logic [motion_pkg::free_bits-1:0]  free_slots,
  input  logic                              move_complete,
  input  logic                              running,
  output motion_pkg::status_t               tx_word,
  output logic                              push,
  output motion_pkg::move_t                 push_move,
  output logic [motion_pkg::num_motors-1:0] enable_out
);
  import motion_pkg::*;

  typedef enum logic [1:0] {
    idle,
    decode,
    respond
  } state_t;

  state_t               state;
  logic [word_bits-1:0] cmd_word;
  opcode_t              op;
  logic [op_bits-1:0]   last_op;
  logic [7:0]           moves_done;
  logic                 overflow;

  assign op = opcode_t'(cmd_word[op_lsb +: op_bits]);

  // Held stable from capture until the next word arrives
  always_ff @(posedge buffered_clk) begin
    if (state == idle && rx_valid) begin
      cmd_word <= rx_word;
    end
  end

  // Move fields straight out of the command word
  always_comb begin
    push_move.dir      = cmd_word[mask_lsb +: num_motors];
    push_move.inc0     = cmd_word[inc0_lsb +: acc_bits];
    push_move.inc1     = cmd_word[inc1_lsb +: acc_bits];
    push_move.duration = cmd_word[dur_lsb +: dur_bits];
  end

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      state      <= idle;
      push       <= 1'b0;
      enable_out <= '0;
      last_op    <= op_nop;
      moves_done <= '0;
      overflow   <= 1'b0;
    end else begin
      push <= 1'b0;
      if (move_complete) begin
        moves_done <= moves_done + 8'd1;  // Wraps
      end
      case (state)
        idle: begin
          if (rx_valid) begin
            state <= decode;
          end
        end
        decode: begin
          case (op)
            op_enable: enable_out <= cmd_word[mask_lsb +: num_motors];
            op_move: begin
              if (full) begin
                overflow <= 1'b1;   // Move is lost
              end else begin
                push <= 1'b1;
              end
            end
            op_clear: begin
              overflow   <= 1'b0;
              moves_done <= '0;
            end
            default: ;
          endcase
          state <= respond;
        end
        respond: begin
          last_op <= op;  // Echoed in the next transfer
          state   <= idle;
        end
        default: state <= idle;
      endcase
    end
  end

  // Live counters so a later read sees current progress
  always_comb begin
    tx_word            = '0;
    tx_word.last_op    = last_op;
    tx_word.moves_done = moves_done;
    tx_word.free_slots = free_slots;
    tx_word.overflow   = overflow;
    tx_word.busy       = running;
    tx_word.enable     = enable_out;
  end

endmodule

// File: src/spi_word_port.sv
// SPI word slave port
`timescale 1ns/1ps

module spi_word_port (
  input  logic                             buffered_clk,
  input  logic                             resetn,
  input  logic                             sck,
  input  logic                             cs_n,
  input  logic                             copi,
  input  motion_pkg::status_t              tx_word,
  output logic                             cipo,
  output logic [motion_pkg::word_bits-1:0] rx_word,
  output logic                             rx_valid
);
  import motion_pkg::*;

  localparam int cnt_bits = $clog2(word_bits) + 1;

  logic [2:0]           sck_s;
  logic [2:0]           cs_s;
  logic [1:0]           copi_s;
  logic                 sck_rise;
  logic                 sck_fall;
  logic                 cs_rise;
  logic                 cs_fall;
  logic                 selected;
  logic [word_bits-1:0] rx_shift;
  logic [word_bits-1:0] tx_shift;
  logic [cnt_bits-1:0]  bit_cnt;
  logic [2:0]           valid_pipe;

  // Edges seen on the second sync stage
  assign sck_rise = sck_s[1] & ~sck_s[2];
  assign sck_fall = ~sck_s[1] & sck_s[2];
  assign cs_rise  = cs_s[1] & ~cs_s[2];
  assign cs_fall  = ~cs_s[1] & cs_s[2];
  assign selected = ~cs_s[1];

  assign cipo     = tx_shift[word_bits-1];  // MSB first
  assign rx_valid = valid_pipe[2];

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      sck_s  <= '0;
      cs_s   <= '1;   // Deselected
      copi_s <= '0;
    end else begin
      sck_s  <= {sck_s[1:0], sck};
      cs_s   <= {cs_s[1:0], cs_n};
      copi_s <= {copi_s[0], copi};
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (!resetn) begin
      bit_cnt    <= '0;
      valid_pipe <= '0;
    end else begin
      if (cs_fall) begin
        bit_cnt <= '0;
      end else if (selected && sck_rise && bit_cnt != cnt_bits'(word_bits)) begin
        bit_cnt <= bit_cnt + 1'b1;  // Saturates at a full word
      end
      // Three-stage delay from CS rise to rx_valid
      valid_pipe <= {valid_pipe[1:0], cs_rise && bit_cnt == cnt_bits'(word_bits)};
    end
  end

  always_ff @(posedge buffered_clk) begin
    if (selected && sck_rise) begin
      rx_shift <= {rx_shift[word_bits-2:0], copi_s[1]};
    end
    if (cs_fall) begin
      tx_shift <= tx_word;   // Status snapshot for this transfer
    end else if (selected && sck_fall) begin
      tx_shift <= {tx_shift[word_bits-2:0], 1'b0};
    end
    if (cs_rise) begin
      rx_word <= rx_shift;
    end
  end

endmodule

// File: src/motion_pkg.sv
// Motion controller shared types
package motion_pkg;

  localparam int num_motors = 2;
  localparam int word_bits  = 64;
  localparam int acc_bits   = 16;  // DDA accumulator and increment
  localparam int dur_bits   = 16;  // Move length in ticks
  localparam int op_bits    = 8;
  localparam int free_bits  = 4;

  // Command word field positions
  localparam int op_lsb   = 56;
  localparam int mask_lsb = 48;  // Dir for moves, enable mask otherwise
  localparam int inc0_lsb = 32;
  localparam int inc1_lsb = 16;
  localparam int dur_lsb  = 0;

  typedef enum logic [op_bits-1:0] {
    op_nop    = 8'h00,
    op_enable = 8'h01,
    op_move   = 8'h02,
    op_clear  = 8'h03   // Clears overflow and completed-move count
  } opcode_t;

  typedef struct packed {
    logic [num_motors-1:0] dir;
    logic [acc_bits-1:0]   inc0;
    logic [acc_bits-1:0]   inc1;
    logic [dur_bits-1:0]   duration;
  } move_t;

  // Status word shifted out on every transfer
  typedef struct packed {
    logic [op_bits-1:0]    last_op;
    logic [39:0]           rsvd;
    logic [7:0]            moves_done;
    logic [free_bits-1:0]  free_slots;
    logic                  overflow;
    logic                  busy;
    logic [num_motors-1:0] enable;
  } status_t;

endpackage
